// ==== hw/te_reg_pkg.sv ====
// host bus widths, register offsets, host request struct and channel mask type
`default_nettype none

package te_reg_pkg;

	// -----------------------------------------------------------------------
	// host bus
	// -----------------------------------------------------------------------
	localparam int TE_ADDR_W = 14;
	localparam int TE_DATA_W = 32;

	// register offsets, decoded on the low 6 address bits
	typedef enum logic [5:0] {
		REG_CHANNEL_ENABLE = 6'h00,
		REG_COH_DATA_READY = 6'h04,
		REG_CURR_STATE     = 6'h08
	} te_reg_addr_e;

	// one host cycle, strobe based
	typedef struct packed {
		logic                 reg_cs;  // register space select
		logic                 buf_cs;  // buffer space select
		logic                 rd;
		logic                 wr;
		logic [TE_ADDR_W-1:0] addr;
		logic [TE_DATA_W-1:0] wdata;
	} te_host_req_t;

	// one bit per logical channel
	typedef logic [31:0] te_chan_mask_t;

endpackage

`default_nettype wire

// ==== hw/te_ctrl_pkg.sv ====
// sequencer states, channel and sample types, FIFO and slot structs
`default_nettype none

package te_ctrl_pkg;

	// encodings kept from the full engine, dropped states leave gaps
	typedef enum logic [3:0] {
		IDLE         = 4'd0,
		START        = 4'd1,
		FIND_CHANNEL = 4'd2,
		READ_FIFO    = 4'd5,
		CORRELATION  = 4'd6,
		COHERENT_SUM = 4'd7,
		COR_FINISH   = 4'd9,
		TE_FINISH    = 4'd10,
		WAIT_CPU     = 4'd11,
		STAND_BY     = 4'd12
	} te_state_e;

	localparam int NUM_LOGIC  = 32;
	localparam int BUF_ADDR_W = 10;

	typedef logic [4:0]         chan_idx_t;
	typedef logic signed [7:0]  sample_t;
	typedef logic signed [15:0] acc_t;   // wraps, no saturation

	// from the sample FIFO
	typedef struct packed {
		logic    ready;  // a full block is waiting
		logic    last;   // final sample of the block
		logic    valid;
		sample_t data;
	} fifo_in_t;

	// to the sample FIFO, one-cycle strobes
	typedef struct packed {
		logic read;
		logic rewind;
		logic skip;
	} fifo_cmd_t;

	typedef struct packed {
		logic      en;
		chan_idx_t idx;
	} slot_t;

endpackage

`default_nettype wire

// ==== hw/te_regs.sv ====
// te_regs: channel enable and coherent-ready registers, state readback, read mux
`timescale 1ns/1ps
`default_nettype none

module te_regs (
	input  wire logic                      clk,
	input  wire logic                      rst_b,
	input  wire te_reg_pkg::te_host_req_t  i_host,
	input  wire te_ctrl_pkg::te_state_e    i_state,
	input  wire te_ctrl_pkg::te_state_e    i_next_state,
	input  wire te_reg_pkg::te_chan_mask_t i_coh_set,
	input  wire logic                      i_coh_set_en,
	input  wire logic                      i_round_clear,
	output te_reg_pkg::te_chan_mask_t      o_chan_enable,
	output logic                           o_ready,
	output logic [31:0]                    o_rdata
);

	te_reg_pkg::te_chan_mask_t coh_ready;
	logic [5:0]                reg_off;
	logic                      host_wr;

	assign reg_off = i_host.addr[5:0];
	assign host_wr = i_host.reg_cs & i_host.wr;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			o_chan_enable <= '0;
		else if (host_wr && reg_off == te_reg_pkg::REG_CHANNEL_ENABLE)
			o_chan_enable <= i_host.wdata;
	end

	// host write beats the engine update
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			coh_ready <= '0;
		else if (host_wr && reg_off == te_reg_pkg::REG_COH_DATA_READY)
			coh_ready <= i_host.wdata;
		else if (i_coh_set_en)
			coh_ready <= coh_ready | i_coh_set;
		else if (i_round_clear)  // new round
			coh_ready <= '0;
	end

	assign o_ready = |coh_ready;

	// read data valid in the same cycle
	always_comb begin
		o_rdata = '0;
		if (i_host.reg_cs && i_host.rd) begin
			case (reg_off)
				te_reg_pkg::REG_CHANNEL_ENABLE: o_rdata = o_chan_enable;
				te_reg_pkg::REG_COH_DATA_READY: o_rdata = coh_ready;
				te_reg_pkg::REG_CURR_STATE:
					o_rdata = {12'h0, i_next_state, 12'h0, i_state};
				default:                        o_rdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/te_sequencer.sv ====
// te_sequencer: engine FSM, correlation-done delay line, FIFO command strobes
`timescale 1ns/1ps
`default_nettype none

module te_sequencer #(
	parameter int COR_LATENCY = 5
) (
	input  wire logic                   clk,
	input  wire logic                   rst_b,
	input  wire logic                   i_start,
	input  wire logic                   i_fifo_ready,
	input  wire logic                   i_fifo_last,
	input  wire logic                   i_any_enabled,
	input  wire logic                   i_find_done,
	input  wire logic                   i_remaining_empty,
	input  wire logic                   i_sum_done,
	output te_ctrl_pkg::te_state_e      o_state,
	output te_ctrl_pkg::te_state_e      o_next_state,
	output te_ctrl_pkg::fifo_cmd_t      o_fifo_cmd,
	output logic                        o_find_start,
	output logic                        o_sum_start,
	output logic                        o_round_clear,
	output logic                        o_running,
	output logic                        o_over
);

	logic [COR_LATENCY-1:0] last_d;  // last sample delay line
	logic                   cor_done;

	//--------------------------------------------------------------------------
	// state machine
	//--------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			o_state <= te_ctrl_pkg::STAND_BY;
		else
			o_state <= o_next_state;
	end

	always_comb begin
		case (o_state)
			te_ctrl_pkg::STAND_BY:
				o_next_state = i_start ? te_ctrl_pkg::IDLE : te_ctrl_pkg::STAND_BY;
			te_ctrl_pkg::IDLE:
				o_next_state = i_fifo_ready ? te_ctrl_pkg::START : te_ctrl_pkg::IDLE;
			te_ctrl_pkg::START:
				o_next_state = i_any_enabled ? te_ctrl_pkg::FIND_CHANNEL : te_ctrl_pkg::TE_FINISH;
			te_ctrl_pkg::FIND_CHANNEL:
				o_next_state = i_find_done ? te_ctrl_pkg::READ_FIFO : te_ctrl_pkg::FIND_CHANNEL;
			te_ctrl_pkg::READ_FIFO:    o_next_state = te_ctrl_pkg::CORRELATION;
			te_ctrl_pkg::CORRELATION:
				o_next_state = cor_done ? te_ctrl_pkg::COHERENT_SUM : te_ctrl_pkg::CORRELATION;
			te_ctrl_pkg::COHERENT_SUM:
				o_next_state = i_sum_done ? te_ctrl_pkg::COR_FINISH : te_ctrl_pkg::COHERENT_SUM;
			te_ctrl_pkg::COR_FINISH:
				o_next_state = i_remaining_empty ? te_ctrl_pkg::TE_FINISH : te_ctrl_pkg::FIND_CHANNEL;
			te_ctrl_pkg::TE_FINISH:    o_next_state = te_ctrl_pkg::WAIT_CPU;
			te_ctrl_pkg::WAIT_CPU:
				o_next_state = i_start ? te_ctrl_pkg::IDLE : te_ctrl_pkg::WAIT_CPU;
			default:                   o_next_state = te_ctrl_pkg::STAND_BY;
		endcase
	end

	// correlators settle COR_LATENCY cycles after the last sample
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			last_d <= '0;
		else
			last_d <= (last_d << 1) | COR_LATENCY'(i_fifo_last);
	end

	assign cor_done = last_d[COR_LATENCY-1];

	//--------------------------------------------------------------------------
	// FIFO strobes, registered from the next state
	//--------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			o_fifo_cmd <= '0;
		end else begin
			o_fifo_cmd.read   <= (o_next_state == te_ctrl_pkg::READ_FIFO);
			o_fifo_cmd.rewind <= (o_next_state == te_ctrl_pkg::COR_FINISH) && !i_remaining_empty;
			o_fifo_cmd.skip   <= (o_next_state == te_ctrl_pkg::TE_FINISH);
		end
	end

	assign o_find_start  = (o_state != te_ctrl_pkg::FIND_CHANNEL) &&
		(o_next_state == te_ctrl_pkg::FIND_CHANNEL);
	assign o_sum_start   = (o_state != te_ctrl_pkg::COHERENT_SUM) &&
		(o_next_state == te_ctrl_pkg::COHERENT_SUM);
	assign o_round_clear = (o_next_state == te_ctrl_pkg::START);
	assign o_running     = (o_state != te_ctrl_pkg::WAIT_CPU) && (o_state != te_ctrl_pkg::STAND_BY);
	assign o_over        = (o_state == te_ctrl_pkg::TE_FINISH);

endmodule

`default_nettype wire

// ==== hw/channel_finder.sv ====
// channel_finder: serial scan of the remaining mask, fills physical slots in order
`timescale 1ns/1ps
`default_nettype none

module channel_finder #(
	parameter int NUM_PHYS = 4
) (
	input  wire logic                          clk,
	input  wire logic                          rst_b,
	input  wire logic                          i_latch,
	input  wire te_reg_pkg::te_chan_mask_t     i_enable,
	input  wire logic                          i_start,
	output logic                               o_done,
	output logic                               o_remaining_empty,
	output te_ctrl_pkg::slot_t [NUM_PHYS-1:0]  o_slots
);

	localparam int PTR_W = $clog2(NUM_PHYS + 1);

	te_reg_pkg::te_chan_mask_t remain;  // channels not served this round
	te_ctrl_pkg::chan_idx_t    idx;
	logic [PTR_W-1:0]          ptr;     // next free slot
	logic                      busy;
	logic                      hit;
	logic                      full_next;
	logic                      last_idx;

	assign hit       = busy && remain[idx];
	assign full_next = hit && (ptr == PTR_W'(NUM_PHYS - 1));
	assign last_idx  = (idx == te_ctrl_pkg::chan_idx_t'(te_ctrl_pkg::NUM_LOGIC - 1));

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			remain  <= '0;
			idx     <= '0;
			ptr     <= '0;
			busy    <= 1'b0;
			o_done  <= 1'b0;
			o_slots <= '0;
		end else begin
			o_done <= 1'b0;
			if (i_latch)
				remain <= i_enable;
			if (i_start) begin
				busy    <= 1'b1;
				idx     <= '0;
				ptr     <= '0;
				o_slots <= '0;  // previous group released
			end else if (busy) begin
				if (hit) begin
					o_slots[ptr] <= '{en: 1'b1, idx: idx};
					remain[idx]  <= 1'b0;
					ptr          <= ptr + 1'b1;
				end
				idx <= idx + 1'b1;
				if (full_next || last_idx) begin
					busy   <= 1'b0;
					o_done <= 1'b1;
				end
			end
		end
	end

	assign o_remaining_empty = ~|remain;

endmodule

`default_nettype wire

// ==== hw/block_correlator.sv ====
// block_correlator: signed sample accumulator for one physical slot
`timescale 1ns/1ps
`default_nettype none

module block_correlator (
	input  wire logic                 clk,
	input  wire logic                 rst_b,
	input  wire logic                 i_clear,
	input  wire logic                 i_valid,
	input  wire te_ctrl_pkg::sample_t i_sample,
	output te_ctrl_pkg::acc_t         o_acc
);

	// sum of one FIFO block, restarted by the read strobe
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			o_acc <= '0;
		else if (i_clear)
			o_acc <= '0;
		else if (i_valid)
			o_acc <= o_acc + te_ctrl_pkg::acc_t'(i_sample);  // sign extended, wraps
	end

endmodule

`default_nettype wire

// ==== hw/coherent_sum.sv ====
// coherent_sum: buffer read-modify-write per enabled slot, updated channel mask
`timescale 1ns/1ps
`default_nettype none

module coherent_sum #(
	parameter int NUM_PHYS = 4
) (
	input  wire logic                              clk,
	input  wire logic                              rst_b,
	input  wire logic                              i_start,
	input  wire te_ctrl_pkg::slot_t [NUM_PHYS-1:0] i_slots,
	input  wire te_ctrl_pkg::acc_t [NUM_PHYS-1:0]  i_accs,
	input  wire logic [31:0]                       i_rdata,
	output logic                                   o_rd,
	output logic                                   o_wr,
	output logic [te_ctrl_pkg::BUF_ADDR_W-1:0]     o_addr,
	output logic [31:0]                            o_wdata,
	output logic                                   o_done,
	output te_reg_pkg::te_chan_mask_t              o_set_mask
);

	localparam int PTR_W = $clog2(NUM_PHYS + 1);
	localparam int AW    = te_ctrl_pkg::BUF_ADDR_W;

	typedef enum logic [1:0] {SUM_IDLE, SUM_RD, SUM_ADD, SUM_WR} sum_state_e;

	sum_state_e         state;
	logic [PTR_W-1:0]   ptr;
	te_ctrl_pkg::slot_t cur_slot;
	te_ctrl_pkg::acc_t  cur_acc;
	logic [31:0]        sum_q;

	// slot under service, empty once the walk runs past the last slot
	always_comb begin
		cur_slot = '0;
		cur_acc  = '0;
		for (int k = 0; k < NUM_PHYS; k++) begin
			if (ptr == PTR_W'(k)) begin
				cur_slot = i_slots[k];
				cur_acc  = i_accs[k];
			end
		end
	end

	// slots fill from 0 upward so the first free one ends the walk
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			state      <= SUM_IDLE;
			ptr        <= '0;
			o_set_mask <= '0;
		end else begin
			case (state)
				SUM_IDLE: if (i_start) begin
					state      <= SUM_RD;
					ptr        <= '0;
					o_set_mask <= '0;
				end
				SUM_RD:  state <= cur_slot.en ? SUM_ADD : SUM_IDLE;
				SUM_ADD: state <= SUM_WR;
				SUM_WR: begin
					o_set_mask[cur_slot.idx] <= 1'b1;
					ptr                      <= ptr + 1'b1;
					state                    <= SUM_RD;
				end
				default: state <= SUM_IDLE;
			endcase
		end
	end

	// buffer word arrives the cycle after the read
	always_ff @(posedge clk) begin
		if (state == SUM_ADD)
			sum_q <= i_rdata + {{16{cur_acc[15]}}, cur_acc};
	end

	assign o_rd    = (state == SUM_RD) && cur_slot.en;
	assign o_done  = (state == SUM_RD) && !cur_slot.en;
	assign o_wr    = (state == SUM_WR);
	assign o_addr  = AW'(cur_slot.idx);  // one word per logical channel
	assign o_wdata = sum_q;

endmodule

`default_nettype wire

// ==== hw/te_buffer.sv ====
// te_buffer: 1024x32 single-port coherent buffer, engine/host port select
`timescale 1ns/1ps
`default_nettype none

module te_buffer (
	input  wire logic                              clk,
	input  wire logic                              i_engine_sel,
	input  wire logic                              i_eng_rd,
	input  wire logic                              i_eng_wr,
	input  wire logic [te_ctrl_pkg::BUF_ADDR_W-1:0] i_eng_addr,
	input  wire logic [31:0]                       i_eng_wdata,
	input  wire te_reg_pkg::te_host_req_t          i_host,
	output logic [31:0]                            o_rdata
);

	localparam int DEPTH = 2 ** te_ctrl_pkg::BUF_ADDR_W;

	logic [31:0]                       mem [DEPTH];
	logic                              rd;
	logic                              wr;
	logic [te_ctrl_pkg::BUF_ADDR_W-1:0] addr;
	logic [31:0]                       wdata;

	// host is locked out while the engine owns the port
	assign rd    = i_engine_sel ? i_eng_rd : (i_host.buf_cs & i_host.rd);
	assign wr    = i_engine_sel ? i_eng_wr : (i_host.buf_cs & i_host.wr);
	assign addr  = i_engine_sel ? i_eng_addr : i_host.addr[te_ctrl_pkg::BUF_ADDR_W-1:0];
	assign wdata = i_engine_sel ? i_eng_wdata : i_host.wdata;

	always_ff @(posedge clk) begin
		if (wr)
			mem[addr] <= wdata;
		if (rd)
			o_rdata <= mem[addr];  // registered read
	end

endmodule

`default_nettype wire

// ==== hw/tracking_engine.sv ====
// tracking_engine: top level with registers, sequencer, finder, correlators and buffer
`timescale 1ns/1ps
`default_nettype none

module tracking_engine #(
	parameter int NUM_PHYS    = 4,
	parameter int COR_LATENCY = 5
) (
	input  wire logic                            clk,
	input  wire logic                            rst_b,
	input  wire logic                            i_start,
	input  wire te_ctrl_pkg::fifo_in_t           i_fifo,
	input  wire te_reg_pkg::te_host_req_t        i_host,
	output te_ctrl_pkg::fifo_cmd_t               o_fifo_cmd,
	output logic                                 o_running,
	output logic                                 o_ready,
	output logic                                 o_over,
	output logic [te_reg_pkg::TE_DATA_W-1:0]     o_reg_rdata,
	output logic [te_reg_pkg::TE_DATA_W-1:0]     o_buf_rdata
);

	te_ctrl_pkg::te_state_e             state;
	te_ctrl_pkg::te_state_e             next_state;
	te_reg_pkg::te_chan_mask_t          chan_enable;
	te_reg_pkg::te_chan_mask_t          coh_set;
	te_ctrl_pkg::slot_t [NUM_PHYS-1:0]  slots;
	te_ctrl_pkg::acc_t [NUM_PHYS-1:0]   accs;
	logic                               find_start;
	logic                               find_done;
	logic                               remaining_empty;
	logic                               sum_start;
	logic                               sum_done;
	logic                               round_clear;
	logic                               eng_rd;
	logic                               eng_wr;
	logic [te_ctrl_pkg::BUF_ADDR_W-1:0] eng_addr;
	logic [31:0]                        eng_wdata;

	//--------------------------------------------------------------------------
	// control
	//--------------------------------------------------------------------------
	te_regs u_regs (
		.clk, .rst_b, .i_host, .i_state(state), .i_next_state(next_state),
		.i_coh_set(coh_set), .i_coh_set_en(sum_done), .i_round_clear(round_clear),
		.o_chan_enable(chan_enable), .o_ready, .o_rdata(o_reg_rdata)
	);

	te_sequencer #(.COR_LATENCY(COR_LATENCY)) u_seq (
		.clk, .rst_b, .i_start, .i_fifo_ready(i_fifo.ready), .i_fifo_last(i_fifo.last),
		.i_any_enabled(|chan_enable), .i_find_done(find_done),
		.i_remaining_empty(remaining_empty), .i_sum_done(sum_done),
		.o_state(state), .o_next_state(next_state), .o_fifo_cmd,
		.o_find_start(find_start), .o_sum_start(sum_start),
		.o_round_clear(round_clear), .o_running, .o_over
	);

	channel_finder #(.NUM_PHYS(NUM_PHYS)) u_finder (
		.clk, .rst_b, .i_latch(round_clear), .i_enable(chan_enable), .i_start(find_start),
		.o_done(find_done), .o_remaining_empty(remaining_empty), .o_slots(slots)
	);

	//--------------------------------------------------------------------------
	// datapath
	//--------------------------------------------------------------------------
	for (genvar g = 0; g < NUM_PHYS; g++) begin : g_cor
		block_correlator u_cor (
			.clk, .rst_b, .i_clear(o_fifo_cmd.read), .i_valid(i_fifo.valid),
			.i_sample(i_fifo.data), .o_acc(accs[g])
		);
	end

	coherent_sum #(.NUM_PHYS(NUM_PHYS)) u_sum (
		.clk, .rst_b, .i_start(sum_start), .i_slots(slots), .i_accs(accs),
		.i_rdata(o_buf_rdata), .o_rd(eng_rd), .o_wr(eng_wr), .o_addr(eng_addr),
		.o_wdata(eng_wdata), .o_done(sum_done), .o_set_mask(coh_set)
	);

	te_buffer u_buf (
		.clk, .i_engine_sel(state == te_ctrl_pkg::COHERENT_SUM), .i_eng_rd(eng_rd),
		.i_eng_wr(eng_wr), .i_eng_addr(eng_addr), .i_eng_wdata(eng_wdata), .i_host,
		.o_rdata(o_buf_rdata)
	);

endmodule

`default_nettype wire

// ==== testbench/te_properties.sv ====
// te_properties: concurrent checks on the sequencer FIFO strobes and o_over, bound into te_sequencer
`timescale 1ns/1ps
`default_nettype none

module te_properties (
	input wire logic                   clk,
	input wire logic                   rst_b,
	input wire logic                   i_over,
	input wire te_ctrl_pkg::fifo_cmd_t i_fifo_cmd
);

	// over marks the single TE_FINISH cycle
	a_over_pulse : assert property (@(posedge clk) disable iff (!rst_b)
		i_over |=> !i_over)
		else $error("o_over stayed high for more than one cycle");

	a_cmd_exclusive : assert property (@(posedge clk) disable iff (!rst_b)
		$onehot0({i_fifo_cmd.read, i_fifo_cmd.rewind, i_fifo_cmd.skip}))
		else $error("more than one FIFO command strobe in the same cycle");

	a_read_single : assert property (@(posedge clk) disable iff (!rst_b)
		i_fifo_cmd.read |=> !i_fifo_cmd.read)  // one block per strobe
		else $error("FIFO read strobe high for two cycles in a row");

endmodule

bind te_sequencer te_properties u_props (
	.clk(clk), .rst_b(rst_b), .i_over(o_over), .i_fifo_cmd(o_fifo_cmd)
);

`default_nettype wire

// ==== testbench/tb_tracking_engine.sv ====
// testbench for tracking_engine: clock, reset, sample FIFO model, host access, directed tests
`timescale 1ns/1ps
`default_nettype none

module tb_tracking_engine;

	localparam int NUM_PHYS    = 4;
	localparam int COR_LATENCY = 5;
	localparam int NUM_BLK     = 6;
	localparam int MAX_LEN     = 20;
	localparam int TIMEOUT     = 2000;  // cycles per wait

	logic                     clk = 1'b0;
	logic                     rst_b = 1'b0;
	logic                     start = 1'b0;
	te_ctrl_pkg::fifo_in_t    fifo_in = '0;
	te_reg_pkg::te_host_req_t host_req = '0;
	te_ctrl_pkg::fifo_cmd_t   fifo_cmd;
	logic                     running;
	logic                     ready;
	logic                     over;
	logic [31:0]              reg_rdata;
	logic [31:0]              buf_rdata;

	te_ctrl_pkg::sample_t samples [NUM_BLK][MAX_LEN];
	int                   blk_len [NUM_BLK];
	int                   cur_blk = 0;
	int                   pos = 0;
	logic                 streaming = 1'b0;
	int                   read_cnt = 0;
	int                   rewind_cnt = 0;
	int                   skip_cnt = 0;
	int                   errors = 0;
	integer               seed;

	tracking_engine #(.NUM_PHYS(NUM_PHYS), .COR_LATENCY(COR_LATENCY)) i_dut (
		.clk, .rst_b, .i_start(start), .i_fifo(fifo_in), .i_host(host_req),
		.o_fifo_cmd(fifo_cmd), .o_running(running), .o_ready(ready), .o_over(over),
		.o_reg_rdata(reg_rdata), .o_buf_rdata(buf_rdata)
	);

	always #4 clk = ~clk;

	// ---------------------------------------------------------------------------
	// sample FIFO model
	// ---------------------------------------------------------------------------
	always @(posedge clk) begin : fifo_model
		int p;
		p = fifo_cmd.read ? 0 : pos;  // a read always restarts the current block
		fifo_in.ready <= 1'b1;
		if (fifo_cmd.read || streaming) begin
			fifo_in.valid <= 1'b1;
			fifo_in.data  <= samples[cur_blk][p];
			fifo_in.last  <= (p == blk_len[cur_blk] - 1);
			streaming     <= (p != blk_len[cur_blk] - 1);
			pos           <= p + 1;
		end else begin
			fifo_in.valid <= 1'b0;
			fifo_in.last  <= 1'b0;
		end
		if (fifo_cmd.read)
			read_cnt <= read_cnt + 1;
		if (fifo_cmd.rewind)
			rewind_cnt <= rewind_cnt + 1;  // block kept for the replay
		if (fifo_cmd.skip) begin
			skip_cnt <= skip_cnt + 1;
			cur_blk  <= (cur_blk + 1) % NUM_BLK;
		end
	end

	// ---------------------------------------------------------------------------
	// reporting and compare tasks
	// ---------------------------------------------------------------------------
	task automatic end_run();
		if (errors == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("test failed");
			$fatal(1, "stopped at the first error");
		end
	endtask

	task automatic report_error(input string line);
		$display("%s", line);
		errors++;
		end_run();
	endtask

	task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			report_error($sformatf("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_mask(input string what, input te_reg_pkg::te_chan_mask_t got,
			input te_reg_pkg::te_chan_mask_t exp);
		if (got !== exp)
			report_error($sformatf("[FAIL] %0t ns %s: mask %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_state(input string what, input te_ctrl_pkg::te_state_e got,
			input te_ctrl_pkg::te_state_e exp);
		if (got !== exp)
			report_error($sformatf("[FAIL] %0t ns %s: state %0d, expected %s",
				$time, what, got, exp.name()));
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp)
			report_error($sformatf("[FAIL] %0t ns %s: got %b, expected %b", $time, what, got, exp));
	endtask

	// wrapped 16-bit block sum, sign extended to a buffer word
	function automatic logic [31:0] block_sum(input int b);
		int total;
		total = 0;
		for (int i = 0; i < blk_len[b]; i++)
			total += int'(samples[b][i]);
		return {{16{total[15]}}, total[15:0]};
	endfunction

	// ---------------------------------------------------------------------------
	// host, start and wait tasks
	// ---------------------------------------------------------------------------
	task automatic host_access(input logic to_buf, input logic do_wr, input logic [13:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		te_reg_pkg::te_host_req_t req;
		req        = '0;
		req.reg_cs = !to_buf;
		req.buf_cs = to_buf;
		req.rd     = !do_wr;
		req.wr     = do_wr;
		req.addr   = addr;
		req.wdata  = wdata;
		@(posedge clk);
		host_req <= req;
		@(negedge clk);
		rdata = reg_rdata;  // register read is combinational
		@(posedge clk);
		host_req <= '0;
		@(negedge clk);
		if (to_buf)
			rdata = buf_rdata;
	endtask

	task automatic pulse_start();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic wait_over();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				report_error("timeout: the engine never pulsed o_over");
		end while (over !== 1'b1);
	endtask

	task automatic wait_read(input int seen);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				report_error("timeout: the engine never sent a FIFO read strobe");
		end while (read_cnt == seen);
	endtask

	task automatic run_pass(input te_reg_pkg::te_chan_mask_t mask);
		logic [31:0] rd;
		host_access(1'b0, 1'b1, 14'(te_reg_pkg::REG_CHANNEL_ENABLE), mask, rd);
		pulse_start();
		wait_over();
		@(negedge clk);
		check_bit("o_over one cycle later", over, 1'b0);
		check_bit("o_running after o_over", running, 1'b0);
	endtask

	task automatic check_enabled_words(input te_reg_pkg::te_chan_mask_t mask,
			input logic [31:0] exp);
		logic [31:0] rd;
		for (int i = 0; i < 32; i++) begin
			if (mask[i]) begin
				host_access(1'b1, 1'b0, 14'(i), '0, rd);
				check_word($sformatf("buffer word %0d", i), rd, exp);
			end
		end
	endtask

	// ---------------------------------------------------------------------------
	// directed tests
	// ---------------------------------------------------------------------------
	task automatic test_reset();
		logic [31:0] rd;
		@(negedge clk);
		check_bit("o_running after reset", running, 1'b0);
		check_bit("o_over after reset", over, 1'b0);
		check_bit("o_ready after reset", ready, 1'b0);
		check_word("FIFO commands after reset", 32'(fifo_cmd), 32'h0);
		host_access(1'b0, 1'b0, 14'(te_reg_pkg::REG_CHANNEL_ENABLE), '0, rd);
		check_mask("channel enable after reset", rd, '0);
		host_access(1'b0, 1'b0, 14'(te_reg_pkg::REG_COH_DATA_READY), '0, rd);
		check_mask("coherent ready after reset", rd, '0);
		host_access(1'b0, 1'b0, 14'(te_reg_pkg::REG_CURR_STATE), '0, rd);
		check_state("current state", te_ctrl_pkg::te_state_e'(rd[3:0]), te_ctrl_pkg::STAND_BY);
		check_state("next state", te_ctrl_pkg::te_state_e'(rd[19:16]), te_ctrl_pkg::STAND_BY);
		check_word("state readback spare bits", rd & 32'hfff0_fff0, 32'h0);
	endtask

	task automatic test_empty_mask();
		int reads0;
		int rewinds0;
		int skips0;
		reads0   = read_cnt;
		rewinds0 = rewind_cnt;
		skips0   = skip_cnt;
		run_pass('0);
		check_word("reads in an empty pass", 32'(read_cnt - reads0), 32'd0);
		check_word("rewinds in an empty pass", 32'(rewind_cnt - rewinds0), 32'd0);
		check_word("skips in an empty pass", 32'(skip_cnt - skips0), 32'd1);
		check_bit("o_ready after an empty pass", ready, 1'b0);
	endtask

	task automatic test_three_channels();
		te_reg_pkg::te_chan_mask_t mask;
		logic [31:0]               exp;
		logic [31:0]               rd;
		mask = 32'h0000_0221;  // channels 0, 5 and 9
		for (int i = 0; i < 32; i++)
			host_access(1'b1, 1'b1, 14'(i), 32'h0, rd);
		exp = block_sum(cur_blk);
		run_pass(mask);
		check_enabled_words(mask, exp);
		host_access(1'b0, 1'b0, 14'(te_reg_pkg::REG_COH_DATA_READY), '0, rd);
		check_mask("coherent ready, three channels", rd, mask);
		check_bit("o_ready, three channels", ready, 1'b1);
	endtask

	task automatic test_six_channels();
		te_reg_pkg::te_chan_mask_t mask;
		logic [31:0]               first;
		logic [31:0]               second;
		logic [31:0]               rd;
		int                        reads0;
		int                        rewinds0;
		mask     = 32'h8040_410a;  // 1, 3, 8, 14, 22, 31 need two groups
		first    = block_sum(cur_blk);
		second   = block_sum((cur_blk + 1) % NUM_BLK);
		reads0   = read_cnt;
		rewinds0 = rewind_cnt;
		run_pass(mask);
		check_word("reads for six channels", 32'(read_cnt - reads0), 32'd2);
		check_word("rewinds for six channels", 32'(rewind_cnt - rewinds0), 32'd1);
		check_enabled_words(mask, first);
		host_access(1'b0, 1'b0, 14'(te_reg_pkg::REG_COH_DATA_READY), '0, rd);
		check_mask("coherent ready, six channels", rd, mask);
		// second round on the next block
		reads0 = read_cnt;
		pulse_start();
		wait_read(reads0);
		host_access(1'b0, 1'b0, 14'(te_reg_pkg::REG_COH_DATA_READY), '0, rd);
		check_mask("coherent ready at round start", rd, '0);
		wait_over();
		@(negedge clk);
		check_bit("o_running after second round", running, 1'b0);
		check_enabled_words(mask, first + second);
		host_access(1'b0, 1'b0, 14'(te_reg_pkg::REG_COH_DATA_READY), '0, rd);
		check_mask("coherent ready after second round", rd, mask);
	endtask

	task automatic test_host_access();
		logic [31:0] rd;
		host_access(1'b0, 1'b1, 14'(te_reg_pkg::REG_COH_DATA_READY), 32'h0, rd);
		check_bit("o_ready after host clear", ready, 1'b0);
		host_access(1'b0, 1'b0, 14'(te_reg_pkg::REG_COH_DATA_READY), '0, rd);
		check_mask("coherent ready after host clear", rd, '0);
		host_access(1'b1, 1'b1, 14'h2a3, 32'hc0de_5a17, rd);
		host_access(1'b1, 1'b0, 14'h2a3, '0, rd);
		check_word("host buffer readback", rd, 32'hc0de_5a17);
	endtask

	initial begin : main
		seed = 32'h401d_1a2c;
		for (int b = 0; b < NUM_BLK; b++) begin
			blk_len[b] = 8 + int'($unsigned($random(seed)) % 13);
			for (int i = 0; i < MAX_LEN; i++)
				samples[b][i] = te_ctrl_pkg::sample_t'($random(seed));
		end
		repeat (5) @(posedge clk);
		rst_b <= 1'b1;
		test_reset();
		test_empty_mask();
		test_three_channels();
		test_six_channels();
		test_host_access();
		end_run();
	end

endmodule

`default_nettype wire

// ==== sim.f ====
hw/te_reg_pkg.sv
hw/te_ctrl_pkg.sv
hw/te_regs.sv
hw/te_sequencer.sv
hw/channel_finder.sv
hw/block_correlator.sv
hw/coherent_sum.sv
hw/te_buffer.sv
hw/tracking_engine.sv
testbench/te_properties.sv
testbench/tb_tracking_engine.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the tracking engine testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_tracking_engine \
	--Mdir "$BUILD_DIR" -f sim.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "build failed"
	exit 1
fi

"./$BUILD_DIR/Vtb_tracking_engine" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "test failed" "$SIM_LOG" || [ $sim_status -ne 0 ]; then
	echo "simulation reported a failure"
	exit 1
fi
exit 0
